//--- source/aes_pkg.sv
package aes_pkg;

  typedef logic [7:0]   aes_byte_t;
  // One column, row 0 in the top byte
  typedef logic [31:0]  aes_word_t;
  // Column-major, column 0 in the top word
  typedef logic [127:0] aes_state_t;

  localparam int NUM_ROUNDS     = 10;
  localparam int NUM_ROUND_KEYS = NUM_ROUNDS + 1;

  // Round key 0 sits at index 0
  typedef aes_state_t [NUM_ROUND_KEYS-1:0] aes_round_keys_t;

  // Forward S-box
  localparam aes_byte_t SBOX [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Round constants for key schedule rounds 1 to 10
  localparam aes_byte_t RCON [0:NUM_ROUNDS-1] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

endpackage

//--- source/aes_round.sv
`timescale 1ns/1ns

module aes_round import aes_pkg::*; #(
  parameter bit FINAL_ROUND = 1'b0
) (
  input  aes_state_t state_in,
  input  aes_state_t round_key,
  output aes_state_t state_out
);

  // Reduction polynomial x^8 + x^4 + x^3 + x + 1, low byte
  localparam aes_byte_t GF_POLY = 8'h1b;

  aes_state_t shifted;
  aes_state_t mixed;

  function automatic aes_byte_t get_byte(aes_state_t s, int col, int row);
    return s[127 - 32*col - 8*row -: 8];
  endfunction

  function automatic aes_byte_t xtime(aes_byte_t b);
    return {b[6:0], 1'b0} ^ (GF_POLY & {8{b[7]}});
  endfunction

  function automatic aes_word_t mix_column(aes_word_t w);
    aes_byte_t b0;
    aes_byte_t b1;
    aes_byte_t b2;
    aes_byte_t b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    // 3*x computed as 2*x ^ x
    return {xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3,
            b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3,
            b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3,
            xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3)};
  endfunction

  // SubBytes and ShiftRows in one pass, row r rotated left by r
  always_comb begin
    for (int col = 0; col < 4; col++) begin
      for (int row = 0; row < 4; row++) begin
        shifted[127 - 32*col - 8*row -: 8] = SBOX[get_byte(state_in, (col + row) % 4, row)];
      end
    end
  end

  generate
    if (FINAL_ROUND) begin : g_no_mix
      assign mixed = shifted;
    end else begin : g_mix
      always_comb begin
        for (int col = 0; col < 4; col++) begin
          mixed[127 - 32*col -: 32] = mix_column(shifted[127 - 32*col -: 32]);
        end
      end
    end
  endgenerate

  assign state_out = mixed ^ round_key;

endmodule

//--- source/aes_key_expand.sv
`timescale 1ns/1ns

module aes_key_expand import aes_pkg::*; (
  input  aes_state_t      key,
  output aes_round_keys_t round_keys
);

  assign round_keys[0] = key;

  // Each round key derives from the one before it
  for (genvar i = 1; i < NUM_ROUND_KEYS; i++) begin : g_round_key
    aes_word_t prev_w0;
    aes_word_t prev_w1;
    aes_word_t prev_w2;
    aes_word_t prev_w3;
    aes_word_t temp;
    aes_word_t w0;
    aes_word_t w1;
    aes_word_t w2;
    aes_word_t w3;

    assign {prev_w0, prev_w1, prev_w2, prev_w3} = round_keys[i-1];

    // RotWord, SubWord, then Rcon into the top byte
    assign temp = {SBOX[prev_w3[23:16]] ^ RCON[i-1],
                   SBOX[prev_w3[15:8]],
                   SBOX[prev_w3[7:0]],
                   SBOX[prev_w3[31:24]]};

    assign w0 = prev_w0 ^ temp;
    assign w1 = w0 ^ prev_w1;
    assign w2 = w1 ^ prev_w2;
    assign w3 = w2 ^ prev_w3;

    assign round_keys[i] = {w0, w1, w2, w3};
  end

endmodule

//--- source/aes_round_stage.sv
`timescale 1ns/1ns

module aes_round_stage import aes_pkg::*; #(
  parameter int FIRST_ROUND = 1,
  parameter int LAST_ROUND  = NUM_ROUNDS
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid_in,
  input  aes_state_t      state_in,
  input  aes_round_keys_t keys_in,
  output logic            valid_out,
  output aes_state_t      state_out,
  output aes_round_keys_t keys_out
);

  localparam int STAGE_ROUNDS = LAST_ROUND - FIRST_ROUND + 1;

  // chain[0] is the stage input, chain[STAGE_ROUNDS] the last round result
  aes_state_t chain [STAGE_ROUNDS+1];

  assign chain[0] = state_in;

  for (genvar i = 0; i < STAGE_ROUNDS; i++) begin : g_round
    aes_round #(
      .FINAL_ROUND(FIRST_ROUND + i == NUM_ROUNDS)
    ) u_round (
      .state_in (chain[i]),
      .round_key(keys_in[FIRST_ROUND + i]),
      .state_out(chain[i+1])
    );
  end

  // Keys move with the block so every block sees its own schedule
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      state_out <= '0;
      keys_out  <= '0;
    end else begin
      valid_out <= valid_in;
      state_out <= chain[STAGE_ROUNDS];
      keys_out  <= keys_in;
    end
  end

endmodule

//--- source/aes_encrypt_pipe.sv
`timescale 1ns/1ns

module aes_encrypt_pipe import aes_pkg::*; #(
  parameter int STAGE_A_LAST = 3,
  parameter int STAGE_B_LAST = 6
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       valid_in,
  input  aes_state_t plaintext,
  input  aes_state_t key,
  output logic       valid_output,
  output aes_state_t ciphertext
);

  aes_round_keys_t round_keys;

  // Stage 0 register
  logic            valid_0;
  aes_state_t      state_0;
  aes_round_keys_t keys_0;

  logic            valid_a;
  aes_state_t      state_a;
  aes_round_keys_t keys_a;

  logic            valid_b;
  aes_state_t      state_b;
  aes_round_keys_t keys_b;

  aes_key_expand u_key_expand (
    .key       (key),
    .round_keys(round_keys)
  );

  // Initial AddRoundKey
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_0 <= 1'b0;
      state_0 <= '0;
      keys_0  <= '0;
    end else begin
      valid_0 <= valid_in;
      state_0 <= plaintext ^ round_keys[0];
      keys_0  <= round_keys;
    end
  end

  aes_round_stage #(
    .FIRST_ROUND(1),
    .LAST_ROUND (STAGE_A_LAST)
  ) stage_a (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_0),
    .state_in (state_0),
    .keys_in  (keys_0),
    .valid_out(valid_a),
    .state_out(state_a),
    .keys_out (keys_a)
  );

  aes_round_stage #(
    .FIRST_ROUND(STAGE_A_LAST + 1),
    .LAST_ROUND (STAGE_B_LAST)
  ) stage_b (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_a),
    .state_in (state_a),
    .keys_in  (keys_a),
    .valid_out(valid_b),
    .state_out(state_b),
    .keys_out (keys_b)
  );

  // Final stage, keys are no longer needed past it
  aes_round_stage #(
    .FIRST_ROUND(STAGE_B_LAST + 1),
    .LAST_ROUND (NUM_ROUNDS)
  ) stage_c (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_b),
    .state_in (state_b),
    .keys_in  (keys_b),
    .valid_out(valid_output),
    .state_out(ciphertext),
    .keys_out ()
  );

endmodule

//--- tb/aes_ref_model.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Software AES-128, state bytes kept in FIPS-197 input order

logic [7:0] model_sbox [256];

function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ x;
    end
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// a^254 is the inverse, and maps 0 to 0
function automatic logic [7:0] mul_inverse(logic [7:0] a);
  logic [7:0] r;
  r = 8'h01;
  for (int i = 0; i < 254; i++) begin
    r = gf_mul(r, a);
  end
  return r;
endfunction

function automatic logic [7:0] affine(logic [7:0] b);
  return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

task automatic build_sbox();
  for (int i = 0; i < 256; i++) begin
    model_sbox[i] = affine(mul_inverse(i[7:0]));
  end
endtask

function automatic logic [127:0] encrypt_block(logic [127:0] pt, logic [127:0] k);
  logic [7:0]   st [16];
  logic [7:0]   tmp [16];
  logic [7:0]   w [176];
  logic [7:0]   t [4];
  logic [7:0]   rc;
  logic [127:0] result;
  rc = 8'h01;
  for (int i = 0; i < 16; i++) begin
    w[i] = k[127-8*i -: 8];
    st[i] = pt[127-8*i -: 8] ^ w[i];
  end
  // Key schedule, 44 words
  for (int i = 4; i < 44; i++) begin
    for (int j = 0; j < 4; j++) begin
      t[j] = w[4*(i-1)+j];
    end
    if (i % 4 == 0) begin
      t[0] = model_sbox[w[4*i-3]] ^ rc;
      t[1] = model_sbox[w[4*i-2]];
      t[2] = model_sbox[w[4*i-1]];
      t[3] = model_sbox[w[4*i-4]];
      rc = gf_mul(rc, 8'h02);
    end
    for (int j = 0; j < 4; j++) begin
      w[4*i+j] = w[4*(i-4)+j] ^ t[j];
    end
  end
  for (int r = 1; r <= 10; r++) begin
    for (int c = 0; c < 4; c++) begin
      for (int rr = 0; rr < 4; rr++) begin
        tmp[4*c+rr] = model_sbox[st[4*((c+rr)%4)+rr]];
      end
    end
    for (int c = 0; c < 4; c++) begin
      if (r < 10) begin
        st[4*c]   = gf_mul(tmp[4*c], 8'h02) ^ gf_mul(tmp[4*c+1], 8'h03)
                    ^ tmp[4*c+2] ^ tmp[4*c+3];
        st[4*c+1] = tmp[4*c] ^ gf_mul(tmp[4*c+1], 8'h02)
                    ^ gf_mul(tmp[4*c+2], 8'h03) ^ tmp[4*c+3];
        st[4*c+2] = tmp[4*c] ^ tmp[4*c+1] ^ gf_mul(tmp[4*c+2], 8'h02)
                    ^ gf_mul(tmp[4*c+3], 8'h03);
        st[4*c+3] = gf_mul(tmp[4*c], 8'h03) ^ tmp[4*c+1] ^ tmp[4*c+2]
                    ^ gf_mul(tmp[4*c+3], 8'h02);
      end else begin
        for (int rr = 0; rr < 4; rr++) begin
          st[4*c+rr] = tmp[4*c+rr];
        end
      end
    end
    for (int i = 0; i < 16; i++) begin
      st[i] = st[i] ^ w[16*r+i];
    end
  end
  for (int i = 0; i < 16; i++) begin
    result[127-8*i -: 8] = st[i];
  end
  return result;
endfunction

`endif

//--- tb/aes_encrypt_pipe_tb.sv
`timescale 1ns/1ns

module aes_encrypt_pipe_tb;

  localparam int LATENCY        = 4;
  localparam int TIMEOUT_CYCLES = 2000;

  logic         clk;
  logic         reset;
  logic         valid_in;
  logic [127:0] plaintext;
  logic [127:0] key;
  logic         valid_output;
  logic [127:0] ciphertext;

  integer seed;
  int     error_count;
  int     cycle_count;
  string  test_name;

  // Expected results and the cycle each block was driven in
  logic [127:0] pred_data [$];
  int           pred_cycle [$];

  `include "aes_ref_model.svh"

  aes_encrypt_pipe UUT (
    .clk         (clk),
    .reset       (reset),
    .valid_in    (valid_in),
    .plaintext   (plaintext),
    .key         (key),
    .valid_output(valid_output),
    .ciphertext  (ciphertext)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  // Outputs only change on the rising edge
  always @(negedge clk) begin
    if (valid_output) begin
      if (pred_data.size() == 0) begin
        $display("Unexpected output in %s at cycle %0d: no block outstanding",
                 test_name, cycle_count);
        error_count++;
      end else begin
        if (cycle_count - pred_cycle[0] != LATENCY) begin
          $display("Mistimed output in %s: block driven in cycle %0d came out at cycle %0d",
                   test_name, pred_cycle[0], cycle_count);
          error_count++;
        end
        check_value(test_name, pred_data[0], ciphertext);
        void'(pred_data.pop_front());
        void'(pred_cycle.pop_front());
      end
    end else if (pred_data.size() != 0 && cycle_count - pred_cycle[0] >= LATENCY) begin
      $display("Missing output in %s: block driven in cycle %0d never came out",
               test_name, pred_cycle[0]);
      error_count++;
      void'(pred_data.pop_front());
      void'(pred_cycle.pop_front());
    end
  end

  function automatic logic [127:0] random_state();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic drive_block(input logic [127:0] pt, input logic [127:0] k,
                             input logic [127:0] expected);
    @(negedge clk);
    valid_in  = 1'b1;
    plaintext = pt;
    key       = k;
    pred_data.push_back(expected);
    pred_cycle.push_back(cycle_count);
  endtask

  task automatic drive_idle();
    @(negedge clk);
    valid_in = 1'b0;
  endtask

  task automatic wait_drain();
    drive_idle();
    while (pred_data.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_reset_state();
    test_name = "reset_state";
    // Reset is still high here and every register is clear
    check_value(test_name, 128'h0, {127'b0, valid_output});
    check_value(test_name, 128'h0, ciphertext);
    reset = 1'b0;
    // Only the valid bit is defined while the data registers load freely
    for (int i = 0; i < LATENCY; i++) begin
      @(negedge clk);
      check_value(test_name, 128'h0, {127'b0, valid_output});
    end
  endtask

  task automatic known_answer(input string name, input logic [127:0] pt,
                              input logic [127:0] k, input logic [127:0] expected);
    test_name = name;
    // The model must agree with the published vector too
    check_value({name, "_model"}, expected, encrypt_block(pt, k));
    drive_block(pt, k, expected);
    wait_drain();
  endtask

  task automatic stream_back_to_back();
    logic [127:0] pt;
    logic [127:0] k;
    test_name = "back_to_back";
    for (int i = 0; i < 32; i++) begin
      pt = random_state();
      k  = random_state();
      drive_block(pt, k, encrypt_block(pt, k));
    end
    wait_drain();
  endtask

  task automatic stream_gapped();
    logic [127:0] pt;
    logic [127:0] k;
    logic [31:0]  r;
    test_name = "gapped";
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      if (r[0]) begin
        pt = random_state();
        k  = random_state();
        drive_block(pt, k, encrypt_block(pt, k));
      end else begin
        drive_idle();
      end
    end
    wait_drain();
  endtask

  task automatic reset_midstream();
    logic [127:0] pt;
    logic [127:0] k;
    test_name = "reset_midstream";
    for (int i = 0; i < 3; i++) begin
      pt = random_state();
      k  = random_state();
      drive_block(pt, k, encrypt_block(pt, k));
    end
    @(negedge clk);
    valid_in = 1'b0;
    reset    = 1'b1;
    @(posedge clk);
    pred_data.delete();
    pred_cycle.delete();
    @(negedge clk);
    check_value(test_name, 128'h0, {127'b0, valid_output});
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // Any discarded block showing up now is flagged by the monitor
    repeat (LATENCY + 2) @(negedge clk);
    pt = random_state();
    k  = random_state();
    drive_block(pt, k, encrypt_block(pt, k));
    wait_drain();
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    valid_in    = 1'b0;
    plaintext   = '0;
    key         = '0;
    seed        = 32'h0fde_8cfa;
    error_count = 0;
    cycle_count = 0;
    test_name   = "init";
    build_sbox();
    repeat (10) @(posedge clk);
    @(negedge clk);

    check_reset_state();
    known_answer("fips_c1", 128'h00112233445566778899aabbccddeeff,
                 128'h000102030405060708090a0b0c0d0e0f,
                 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    known_answer("fips_b", 128'h3243f6a8885a308d313198a2e0370734,
                 128'h2b7e151628aed2a6abf7158809cf4f3c,
                 128'h3925841d02dc09fbdc118597196a0b32);
    stream_back_to_back();
    stream_gapped();
    reset_midstream();

    $display("Summary: %0d errors after %0d cycles", error_count, cycle_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- aes_encrypt_pipe.f
+incdir+tb
source/aes_pkg.sv
source/aes_round.sv
source/aes_key_expand.sv
source/aes_round_stage.sv
source/aes_encrypt_pipe.sv
tb/aes_encrypt_pipe_tb.sv

//--- Makefile
# Verilator build of the AES-128 pipeline testbench

TOP       ?= aes_encrypt_pipe_tb
FILELIST  ?= aes_encrypt_pipe.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
INCDIRS := $(patsubst +incdir+%,%,$(shell grep '^+incdir+' $(FILELIST)))
HEADERS := $(foreach d,$(INCDIRS),$(wildcard $(d)/*.svh))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from grep, so a missing pass line fails the target
run: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -x 'NO ERRORS' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
